/* verif/pte_cache_stimulus.txt */
# C priv sum mxr | R level vaddr pte0 pte1 pte2 pte3 | F
# L vaddr source kind level addr walker_full, for a miss the level column is miss_ptr_hit
C 1 0 0
L 12345678 1 miss 0 0 0
L 12345678 2 retry 0 0 1
R 0 12344000 02AF34CF 048000CF 00040047 FFFFFC43
L 12345678 1 hit 0 12000678 0
L 12344ABC 1 hit 0 0ABCDABC 0
L 12346010 2 exc 0 0 0
L 12347004 0 exc 0 0 0
L 12347004 1 hit 0 3FFFFF004 0
R 1 80000000 155000CF 155004CF 0120D001 00000000
L 80123456 1 hit 1 55523456 0
L 80400000 1 exc 1 0 0
L 80856789 1 miss 1 04834158 0
L 80856789 1 retry 0 0 1
R 0 00000000 000004CF 00000000 00000000 00000000
L 00000010 1 hit 0 00001010 0
L 80123456 1 hit 1 55523456 0
R 1 12000000 0C0000CF 00000000 00000000 00000000
L 12345678 1 hit 0 12000678 0
L 12012345 1 hit 1 30012345 0
R 0 00008000 000800DF 000C0059 00000000 00000401
L 00008123 1 exc 0 0 0
C 1 1 0
L 00008123 1 hit 0 00200123 0
C 0 0 0
L 12345678 1 exc 0 0 0
L 00009040 1 exc 0 0 0
L 00009040 0 hit 0 00300040 0
C 0 0 1
L 00009040 1 hit 0 00300040 0
C 1 0 0
L 0000A000 1 exc 0 0 0
L 0000B000 1 exc 0 0 0
F
L 12345678 1 miss 0 0 0
L 80856789 1 miss 0 0 0

/* list.f */
hw/pte_cache_pkg.sv
hw/pte_req_decode.sv
hw/pte_store.sv
hw/pte_perm_check.sv
hw/pte_result.sv
hw/pte_cache_top.sv
verif/pte_cache_tb.sv

/* Bender.yml */
package:
  name: pte_cache

sources:
  - hw/pte_cache_pkg.sv
  - hw/pte_req_decode.sv
  - hw/pte_store.sv
  - hw/pte_perm_check.sv
  - hw/pte_result.sv
  - hw/pte_cache_top.sv
  - target: test
    files:
      - verif/pte_cache_tb.sv

/* verif/pte_cache_tb.sv */
`timescale 1ns/100ps

module pte_cache_tb import pte_cache_pkg::*; ();

    localparam int WAIT_CYCLES = 20;

    logic       clk;
    logic       rst_n;
    logic       req;
    vaddr_t     vaddr;
    source_t    source;
    priv_t      priv;
    logic       sum;
    logic       mxr;
    logic       flush;
    logic       refill_req;
    logic [1:0] refill_level;
    vaddr_t     refill_vaddr;
    line_t      refill_line;
    logic       walker_full;
    logic       refill_ready;
    logic       resp_valid;
    logic       resp_exception;
    logic       resp_retry;
    logic       resp_level;
    pte_t       resp_entry;
    paddr_t     resp_paddr;
    logic       miss_req;
    vaddr_t     miss_vaddr;
    source_t    miss_source;
    logic       miss_ptr_hit;
    paddr_t     miss_next_paddr;

    int tests;
    int errors;

    // Lines refilled since the last flush.
    int     fill_level [$];
    vaddr_t fill_vaddr [$];
    line_t  fill_line [$];

    pte_cache_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_hex(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    // Expected entry from the newest refill of the line that covers addr at this level.
    function automatic pte_t refilled_pte(input int level, input vaddr_t addr);
        int    i;
        int    lsb;
        int    ofs;
        line_t line;
        pte_t  pte;
        lsb = (level == 1) ? VPN1_LSB : VPN0_LSB;
        ofs = (addr >> lsb) % PTE_PER_LINE;
        pte = 'x;
        for (i = 0; i < fill_line.size(); i++) begin
            if (fill_level[i] == level &&
                (fill_vaddr[i] >> (lsb + LINE_OFS_W)) == (addr >> (lsb + LINE_OFS_W))) begin
                line = fill_line[i];
                pte  = line[ofs*PTE_BITS +: PTE_BITS];
            end
        end
        return pte;
    endfunction

    task automatic set_csr(input int p, input int s, input int m);
        @(posedge clk);
        priv <= priv_t'(p);
        sum  <= (s != 0);
        mxr  <= (m != 0);
    endtask

    task automatic pulse_flush();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        fill_level.delete();
        fill_vaddr.delete();
        fill_line.delete();
    endtask

    task automatic send_refill(input int level, input vaddr_t addr, input line_t line);
        int n;
        @(posedge clk);
        refill_req   <= 1'b1;
        refill_level <= (level == 1) ? 2'b10 : 2'b01; // One-hot with bit 0 for level 0.
        refill_vaddr <= addr;
        refill_line  <= line;
        for (n = 0; n < WAIT_CYCLES; n++) begin
            @(negedge clk);
            if (refill_ready) break;
        end
        assert (refill_ready) else begin
            $display("Refill at 0x%h was not accepted within %0d cycles", addr, WAIT_CYCLES);
            errors++;
        end
        @(posedge clk);
        refill_req <= 1'b0; // Written on this edge.
        fill_level.push_back(level);
        fill_vaddr.push_back(addr);
        fill_line.push_back(line);
    endtask

    task automatic run_lookup(input vaddr_t addr, input int src, input string kind,
                              input int level, input logic [63:0] exp_addr, input int full);
        int   n;
        int   errors_before;
        logic got_resp;
        logic got_miss;
        errors_before = errors;
        got_resp = 1'b0;
        got_miss = 1'b0;
        @(posedge clk);
        req         <= 1'b1;
        vaddr       <= addr;
        source      <= source_t'(src);
        walker_full <= (full != 0);
        @(posedge clk);
        req <= 1'b0;
        for (n = 0; n < WAIT_CYCLES; n++) begin
            @(negedge clk);
            got_resp = resp_valid;
            got_miss = miss_req;
            if (got_resp || got_miss) break;
        end
        assert (got_resp || got_miss) else begin
            $display("No response or miss request for vaddr 0x%h within %0d cycles",
                     addr, WAIT_CYCLES);
            errors++;
        end
        if (got_resp || got_miss) begin
            check_hex("resp_valid", got_resp, kind != "miss");
            check_hex("miss_req", got_miss, kind == "miss");
            if (kind == "miss") begin
                check_hex("miss_vaddr", miss_vaddr, addr);
                check_hex("miss_source", miss_source, src);
                check_hex("miss_ptr_hit", miss_ptr_hit, level);
                if (level == 1) begin
                    check_hex("miss_next_paddr", miss_next_paddr, exp_addr);
                end
            end else begin
                check_hex("resp_retry", resp_retry, kind == "retry");
                check_hex("resp_exception", resp_exception, kind == "exc");
                if (kind != "retry") begin
                    check_hex("resp_level", resp_level, level);
                    check_hex("resp_entry", resp_entry, refilled_pte(level, addr));
                end
                if (kind == "hit") begin
                    check_hex("resp_paddr", resp_paddr, exp_addr);
                end
            end
        end
        tests++;
        $display("Test %0d: %s at 0x%h, source %0d, %s", tests, kind, addr, src,
                 (errors == errors_before) ? "ok" : "failed");
    endtask

    initial begin
        int            fd;
        int            code;
        int            p;
        int            s;
        int            m;
        int            lvl;
        int            src;
        int            full;
        vaddr_t        addr;
        logic [63:0]   exp_addr;
        pte_t          pte [4];
        string         rec;
        string         kind;
        logic [1023:0] skip_line;

        tests        = 0;
        errors       = 0;
        rst_n        = 1'b0;
        req          = 1'b0;
        vaddr        = '0;
        source       = SRC_FETCH;
        priv         = PRIV_S;
        sum          = 1'b0;
        mxr          = 1'b0;
        flush        = 1'b0;
        refill_req   = 1'b0;
        refill_level = 2'b00;
        refill_vaddr = '0;
        refill_line  = '0;
        walker_full  = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // Idle state straight out of reset.
        @(negedge clk);
        check_hex("resp_valid", resp_valid, 0);
        check_hex("miss_req", miss_req, 0);
        check_hex("refill_ready", refill_ready, 1);
        tests++;
        $display("Test %0d: reset state, %s", tests, (errors == 0) ? "ok" : "failed");

        fd = $fopen("verif/pte_cache_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", rec);
                if (code != 1) break;
                if (rec == "#") begin
                    code = $fgets(skip_line, fd);
                end else if (rec == "C") begin
                    code = $fscanf(fd, "%d %d %d", p, s, m);
                    set_csr(p, s, m);
                end else if (rec == "R") begin
                    code = $fscanf(fd, "%d %h %h %h %h %h", lvl, addr,
                                   pte[0], pte[1], pte[2], pte[3]);
                    send_refill(lvl, addr, {pte[3], pte[2], pte[1], pte[0]});
                end else if (rec == "F") begin
                    pulse_flush();
                end else if (rec == "L") begin
                    code = $fscanf(fd, "%h %d %s %d %h %d", addr, src, kind, lvl,
                                   exp_addr, full);
                    run_lookup(addr, src, kind, lvl, exp_addr, full);
                end else begin
                    $display("Unknown record kind %s in the stimulus file", rec);
                    errors++;
                end
            end
            $fclose(fd);
        end

        repeat (4) @(posedge clk);
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* hw/pte_cache_top.sv */
`timescale 1ns/100ps

module pte_cache_top import pte_cache_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    req,
    input  vaddr_t  vaddr,
    input  source_t source,
    input  priv_t   priv,
    input  logic    sum,
    input  logic    mxr,
    input  logic    flush,
    input  logic    refill_req,
    input  logic [1:0] refill_level,
    input  vaddr_t  refill_vaddr,
    input  line_t   refill_line,
    input  logic    walker_full,
    output logic    refill_ready,
    output logic    resp_valid,
    output logic    resp_exception,
    output logic    resp_retry,
    output logic    resp_level,
    output pte_t    resp_entry,
    output paddr_t  resp_paddr,
    output logic    miss_req,
    output vaddr_t  miss_vaddr,
    output source_t miss_source,
    output logic    miss_ptr_hit,
    output paddr_t  miss_next_paddr
);

    logic [L1_IDX_W-1:0] store_index_l1;
    logic [L0_IDX_W-1:0] store_index_l0;
    logic                store_rd;
    logic                req_q;
    vaddr_t              vaddr_q;
    source_t             source_q;
    logic                hit_l1;
    logic                hit_l0;
    pte_t                entry_l1;
    pte_t                entry_l0;
    logic                exc_l1;
    logic                exc_l0;

    pte_req_decode decode_i (
        .clk, .rst_n, .req, .vaddr, .source, .flush, .refill_req, .refill_vaddr,
        .store_index_l1, .store_index_l0, .store_rd, .req_q, .vaddr_q, .source_q,
        .refill_ready
    );

    pte_store #(.LEVEL(1)) store_l1 (
        .clk, .rst_n, .rd(store_rd), .index(store_index_l1), .vaddr_q, .req_q, .flush,
        .refill_req, .refill_level, .refill_vaddr, .refill_line,
        .hit(hit_l1), .entry(entry_l1)
    );

    pte_store #(.LEVEL(0)) store_l0 (
        .clk, .rst_n, .rd(store_rd), .index(store_index_l0), .vaddr_q, .req_q, .flush,
        .refill_req, .refill_level, .refill_vaddr, .refill_line,
        .hit(hit_l0), .entry(entry_l0)
    );

    pte_perm_check check_l1 (
        .entry(entry_l1), .source(source_q), .priv, .sum, .mxr, .exception(exc_l1)
    );

    pte_perm_check check_l0 (
        .entry(entry_l0), .source(source_q), .priv, .sum, .mxr, .exception(exc_l0)
    );

    pte_result result_i (
        .clk, .rst_n, .req_q, .vaddr_q, .source_q, .flush,
        .hit_l1, .entry_l1, .exc_l1, .hit_l0, .entry_l0, .exc_l0, .walker_full,
        .resp_valid, .resp_exception, .resp_retry, .resp_level, .resp_entry, .resp_paddr,
        .miss_req, .miss_vaddr, .miss_source, .miss_ptr_hit, .miss_next_paddr
    );

endmodule

/* hw/pte_result.sv */
`timescale 1ns/100ps

module pte_result import pte_cache_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    req_q,
    input  vaddr_t  vaddr_q,
    input  source_t source_q,
    input  logic    flush,
    input  logic    hit_l1,
    input  pte_t    entry_l1,
    input  logic    exc_l1,
    input  logic    hit_l0,
    input  pte_t    entry_l0,
    input  logic    exc_l0,
    input  logic    walker_full,
    output logic    resp_valid,
    output logic    resp_exception,
    output logic    resp_retry,
    output logic    resp_level,
    output pte_t    resp_entry,
    output paddr_t  resp_paddr,
    output logic    miss_req,
    output vaddr_t  miss_vaddr,
    output source_t miss_source,
    output logic    miss_ptr_hit,
    output paddr_t  miss_next_paddr
);

    logic leaf_l0;
    logic leaf_l1;
    logic ans_l0;
    logic ans_l1;
    logic answer;
    logic exc_ans;
    logic ptr_l1;

    logic [PTE_PPN1_W-1:0] ppn1_l0;
    logic [PTE_PPN0_W-1:0] ppn0_l0;
    logic [PTE_PPN1_W-1:0] ppn1_l1;
    logic [PTE_PPN0_W-1:0] ppn0_l1;
    vpn_t                  vpn0;
    logic [PAGE_OFS_W-1:0] page_ofs;
    paddr_t                paddr_l0;
    paddr_t                paddr_l1;
    paddr_t                next_paddr;

    assign ppn1_l0  = entry_l0[PTE_PPN1_LSB +: PTE_PPN1_W];
    assign ppn0_l0  = entry_l0[PTE_PPN0_LSB +: PTE_PPN0_W];
    assign ppn1_l1  = entry_l1[PTE_PPN1_LSB +: PTE_PPN1_W];
    assign ppn0_l1  = entry_l1[PTE_PPN0_LSB +: PTE_PPN0_W];
    assign vpn0     = vaddr_q[VPN0_LSB +: VPN_W];
    assign page_ofs = vaddr_q[PAGE_OFS_W-1:0];

    assign leaf_l0 = entry_l0[PTE_R] | entry_l0[PTE_W] | entry_l0[PTE_X];
    assign leaf_l1 = entry_l1[PTE_R] | entry_l1[PTE_W] | entry_l1[PTE_X];

    // Level 0 wins, a non-leaf there is malformed.
    assign ans_l0 = hit_l0;
    assign ans_l1 = ~hit_l0 & hit_l1 & leaf_l1;
    assign answer = ans_l0 | ans_l1;

    // Superpage must be aligned, ppn0 zero.
    assign exc_ans = ans_l0 ? (~leaf_l0 | exc_l0) : (exc_l1 | (|ppn0_l1));

    assign ptr_l1 = hit_l1 & ~leaf_l1 & ~exc_l1;

    assign paddr_l0   = {ppn1_l0, ppn0_l0, page_ofs};
    assign paddr_l1   = {ppn1_l1, vpn0, page_ofs};
    assign next_paddr = {ppn1_l1, ppn0_l1, vpn0, 2'b00}; // Level-0 table base plus vpn0 * 4.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
            miss_req   <= 1'b0;
        end else begin
            resp_valid <= req_q & ~flush & (answer | walker_full);
            miss_req   <= req_q & ~flush & ~answer & ~walker_full;
        end
    end

    always_ff @(posedge clk) begin
        if (req_q) begin
            resp_exception  <= answer & exc_ans;
            resp_retry      <= ~answer;
            resp_level      <= ~ans_l0;
            resp_entry      <= ans_l0 ? entry_l0 : entry_l1;
            resp_paddr      <= ans_l0 ? paddr_l0 : paddr_l1;
            miss_vaddr      <= vaddr_q;
            miss_source     <= source_q;
            miss_ptr_hit    <= ptr_l1;
            miss_next_paddr <= next_paddr;
        end
    end

endmodule

/* hw/pte_perm_check.sv */
`timescale 1ns/100ps

module pte_perm_check import pte_cache_pkg::*; (
    input  pte_t    entry,
    input  source_t source,
    input  priv_t   priv,
    input  logic    sum,
    input  logic    mxr,
    output logic    exception
);

    logic is_fetch;
    logic is_load;
    logic is_store;
    logic leaf;
    logic has_right;
    logic bad_format;
    logic bad_priv;
    logic bad_ad;

    assign is_fetch = (source == SRC_FETCH);
    assign is_load  = (source == SRC_LOAD);
    assign is_store = (source == SRC_STORE);

    assign leaf = entry[PTE_R] | entry[PTE_W] | entry[PTE_X];

    // Reserved encodings apply to pointers as well.
    assign bad_format = ~entry[PTE_V]
                      | (entry[PTE_W] & ~entry[PTE_R])
                      | (|entry[PTE_RSW_LSB +: PTE_RSW_W]);

    assign has_right = (is_fetch & entry[PTE_X])
                     | (is_load & (entry[PTE_R] | (entry[PTE_X] & mxr)))
                     | (is_store & entry[PTE_W]);

    assign bad_priv = ((priv == PRIV_U) & ~entry[PTE_U])
                    | ((priv == PRIV_S) & entry[PTE_U] & ~sum);

    // No hardware A/D update, software must set them.
    assign bad_ad = ~entry[PTE_A] | (is_store & ~entry[PTE_D]);

    assign exception = bad_format | (leaf & (~has_right | bad_priv | bad_ad));

endmodule

/* hw/pte_store.sv */
`timescale 1ns/100ps

module pte_store import pte_cache_pkg::*; #(
    parameter int LEVEL = 0
) (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        rd,
    input  logic [(LEVEL == 1 ? L1_IDX_W : L0_IDX_W)-1:0] index,
    input  vaddr_t                                      vaddr_q,
    input  logic                                        req_q,
    input  logic                                        flush,
    input  logic                                        refill_req,
    input  logic [1:0]                                  refill_level,
    input  vaddr_t                                      refill_vaddr,
    input  line_t                                       refill_line,
    output logic                                        hit,
    output pte_t                                        entry
);

    localparam int SETS    = (LEVEL == 1) ? L1_SETS : L0_SETS;
    localparam int IDX_W   = (LEVEL == 1) ? L1_IDX_W : L0_IDX_W;
    localparam int TAG_W   = (LEVEL == 1) ? L1_TAG_W : L0_TAG_W;
    localparam int OFS_LSB = (LEVEL == 1) ? VPN1_LSB : VPN0_LSB;
    localparam int TAG_LSB = OFS_LSB + LINE_OFS_W + IDX_W;

    logic [SETS-1:0]  valid;
    logic [TAG_W-1:0] tags [SETS];
    line_t            lines [SETS];

    logic             we;
    logic             valid_rd;
    logic [TAG_W-1:0] tag_rd;
    line_t            line_rd;

    logic [TAG_W-1:0]      tag_cmp;
    logic [LINE_OFS_W-1:0] line_ofs;

    assign we = refill_req & refill_level[LEVEL] & ~rd;

    // Valid bits.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (flush) begin
            valid <= '0;
        end else if (we) begin
            valid[index] <= 1'b1;
        end
    end

    // Tag and line arrays.
    always_ff @(posedge clk) begin
        if (we) begin
            tags[index]  <= refill_vaddr[TAG_LSB +: TAG_W];
            lines[index] <= refill_line;
        end
    end

    // One-cycle read.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_rd <= 1'b0;
        end else if (rd) begin
            valid_rd <= valid[index];
        end
    end

    always_ff @(posedge clk) begin
        if (rd) begin
            tag_rd  <= tags[index];
            line_rd <= lines[index];
        end
    end

    assign tag_cmp  = vaddr_q[TAG_LSB +: TAG_W];
    assign line_ofs = vaddr_q[OFS_LSB +: LINE_OFS_W];

    assign hit   = req_q & valid_rd & (tag_rd == tag_cmp);
    assign entry = line_rd[line_ofs*PTE_BITS +: PTE_BITS]; // PTE 0 in the low word.

endmodule

/* hw/pte_req_decode.sv */
`timescale 1ns/100ps

module pte_req_decode import pte_cache_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req,
    input  vaddr_t              vaddr,
    input  source_t             source,
    input  logic                flush,
    input  logic                refill_req,
    input  vaddr_t              refill_vaddr,
    output logic [L1_IDX_W-1:0] store_index_l1,
    output logic [L0_IDX_W-1:0] store_index_l0,
    output logic                store_rd,
    output logic                req_q,
    output vaddr_t              vaddr_q,
    output source_t             source_q,
    output logic                refill_ready
);

    localparam int L1_IDX_LSB = VPN1_LSB + LINE_OFS_W;
    localparam int L0_IDX_LSB = VPN0_LSB + LINE_OFS_W;

    logic [L1_IDX_W-1:0] lookup_idx_l1;
    logic [L0_IDX_W-1:0] lookup_idx_l0;
    logic [L1_IDX_W-1:0] refill_idx_l1;
    logic [L0_IDX_W-1:0] refill_idx_l0;
    logic                refill_pending;

    assign lookup_idx_l1 = vaddr[L1_IDX_LSB +: L1_IDX_W];
    assign lookup_idx_l0 = vaddr[L0_IDX_LSB +: L0_IDX_W];
    assign refill_idx_l1 = refill_vaddr[L1_IDX_LSB +: L1_IDX_W];
    assign refill_idx_l0 = refill_vaddr[L0_IDX_LSB +: L0_IDX_W];

    // A lookup owns the array port, the refill waits.
    assign store_rd       = req;
    assign refill_ready   = ~req;
    assign refill_pending = refill_req & ~req;

    always_comb begin
        if (refill_pending) begin
            store_index_l1 = refill_idx_l1;
            store_index_l0 = refill_idx_l0;
        end else begin
            store_index_l1 = lookup_idx_l1; // Also the idle default.
            store_index_l0 = lookup_idx_l0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q <= 1'b0;
        end else begin
            req_q <= req & ~flush; // Flush kills the request in decode.
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            vaddr_q  <= vaddr;
            source_q <= source;
        end
    end

endmodule

/* hw/pte_cache_pkg.sv */
package pte_cache_pkg;

    // Address and entry widths.
    localparam int VADDR_W    = 32;
    localparam int PADDR_W    = 34;
    localparam int PTE_BITS   = 32;
    localparam int VPN_W      = 10;
    localparam int PAGE_OFS_W = 12;

    // Bit position of each VPN slice in the virtual address.
    localparam int VPN0_LSB = PAGE_OFS_W;
    localparam int VPN1_LSB = PAGE_OFS_W + VPN_W;

    // Refill unit.
    localparam int PTE_PER_LINE = 4;
    localparam int LINE_OFS_W   = 2;

    // Level 1 splits vpn1 as tag, index, line offset.
    localparam int L1_SETS  = 8;
    localparam int L1_IDX_W = 3;
    localparam int L1_TAG_W = 5;

    // Level 0 splits the full VPN the same way.
    localparam int L0_SETS  = 16;
    localparam int L0_IDX_W = 4;
    localparam int L0_TAG_W = 14;

    // Sv32 entry layout. Bit 5 (g) is not used here.
    localparam int PTE_PPN1_LSB = 20;
    localparam int PTE_PPN1_W   = 12;
    localparam int PTE_PPN0_LSB = 10;
    localparam int PTE_PPN0_W   = 10;
    localparam int PTE_RSW_LSB  = 8;
    localparam int PTE_RSW_W    = 2;
    localparam int PTE_D        = 7;
    localparam int PTE_A        = 6;
    localparam int PTE_U        = 4;
    localparam int PTE_X        = 3;
    localparam int PTE_W        = 2;
    localparam int PTE_R        = 1;
    localparam int PTE_V        = 0;

    typedef logic [VADDR_W-1:0]                 vaddr_t;
    typedef logic [PADDR_W-1:0]                 paddr_t;
    typedef logic [PTE_BITS-1:0]                pte_t;
    typedef logic [VPN_W-1:0]                   vpn_t;
    typedef logic [PTE_PER_LINE*PTE_BITS-1:0]   line_t;

    // Access source.
    typedef logic [1:0] source_t;
    localparam source_t SRC_FETCH = 2'd0;
    localparam source_t SRC_LOAD  = 2'd1;
    localparam source_t SRC_STORE = 2'd2;

    // Privilege mode.
    typedef logic [1:0] priv_t;
    localparam priv_t PRIV_U = 2'd0;
    localparam priv_t PRIV_S = 2'd1;

endpackage
